//--- common/radio_defs.svh
//====================
// sizes and register map of the radio port
// register addresses are wishbone word addresses
//====================
`ifndef RADIO_DEFS_SVH
`define RADIO_DEFS_SVH

`define RADIO_SAMPLE_W    12    // one I or Q word on the DDR bus
`define RADIO_REG_CTRL    2'd0  // control, read/write
`define RADIO_REG_STATUS  2'd1  // status, read only
`define RADIO_CNT_W       16    // receive pair counter, wraps

`endif

//--- common/radio_sample_pkg.sv
//====================
// sample types of the data path
// I sits above Q, channel 0 above channel 1
//====================
`include "radio_defs.svh"

package radio_sample_pkg;

  // one complex sample
  typedef struct packed {
    logic [`RADIO_SAMPLE_W-1:0] i;
    logic [`RADIO_SAMPLE_W-1:0] q;
  } iq_sample_t;

  // both channels of one bus period
  typedef struct packed {
    iq_sample_t ch0;
    iq_sample_t ch1;
  } chan_pair_t;

endpackage

//--- common/radio_ctrl_pkg.sv
//====================
// control side types
// wishbone classic, 32-bit data, word addressed
//====================
package radio_ctrl_pkg;

  typedef enum logic {
    MODE_SISO = 1'b0,
    MODE_MIMO = 1'b1
  } bus_mode_t;

  // master to slave
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [1:0]  adr;   // word address
    logic [31:0] dat;   // write data
  } wb_req_t;

  // slave to master
  typedef struct packed {
    logic        ack;
    logic [31:0] dat;   // read data, valid with ack
  } wb_rsp_t;

endpackage

//--- verilog/radio_ctrl_regs.sv
//====================
// wishbone classic slave, one cycle to ack
// master must hold cyc/stb until ack
//====================
`timescale 1ns/1ps
`include "radio_defs.svh"

module radio_ctrl_regs
  import radio_ctrl_pkg::*;
(
  input  logic                    radio_clk,
  input  logic                    radio_rst,
  input  wb_req_t                 wb_req_i,
  output wb_rsp_t                 wb_rsp_o,
  input  bus_mode_t               mode_i,
  input  logic                    tx_active_i,
  input  logic [`RADIO_CNT_W-1:0] rx_count_i,
  output logic                    mimo_req_o,
  output logic                    tx_en_o
);

  logic        ack_q;
  logic [1:0]  ctrl_q;    // [1] tx enable, [0] mimo request
  logic [31:0] rd_dat;
  logic [31:0] rd_dat_q;
  logic        req_go;

  // no new access in the cycle right after an ack
  assign req_go = wb_req_i.cyc & wb_req_i.stb & ~ack_q;

  always_comb begin
    rd_dat = '0;
    case (wb_req_i.adr)
      `RADIO_REG_CTRL:   rd_dat = {30'd0, ctrl_q};
      `RADIO_REG_STATUS: rd_dat = {rx_count_i, 14'd0, tx_active_i, mode_i};
      default:           rd_dat = '0;   // unmapped reads as zero
    endcase
  end

  always_ff @(posedge radio_clk or posedge radio_rst) begin
    if (radio_rst) begin
      ack_q  <= 1'b0;
      ctrl_q <= '0;
    end else begin
      ack_q <= req_go;
      if (req_go && wb_req_i.we && wb_req_i.adr == `RADIO_REG_CTRL) begin
        ctrl_q <= wb_req_i.dat[1:0];
      end
    end
  end

  always_ff @(posedge radio_clk) begin
    if (req_go) rd_dat_q <= rd_dat;
  end

  assign wb_rsp_o.ack = ack_q;
  assign wb_rsp_o.dat = rd_dat_q;
  assign mimo_req_o   = ctrl_q[0];
  assign tx_en_o      = ctrl_q[1];

  // master keeps the request up through the ack cycle
  a_ack_in_cycle : assert property (@(posedge radio_clk) disable iff (radio_rst)
    wb_rsp_o.ack |-> (wb_req_i.cyc && wb_req_i.stb));

endmodule

//--- verilog/radio_mode_fsm.sv
//====================
// mode changes only land on a slot 0 cycle
// transmit is quiet for one cycle around a change
//====================
`timescale 1ns/1ps

module radio_mode_fsm
  import radio_ctrl_pkg::*;
(
  input  logic      radio_clk,
  input  logic      radio_rst,
  input  logic      mimo_req_i,
  input  logic      tx_en_i,
  input  logic      slot_phase_i,
  output bus_mode_t mode_o,
  output logic      tx_active_o
);

  typedef enum logic [1:0] {IDLE, RUN_SISO, RUN_MIMO, SWITCH} state_t;

  state_t    state_q, state_d;
  bus_mode_t mode_q;
  bus_mode_t req_mode;
  logic      mode_chg;

  function automatic state_t run_of(bus_mode_t m);
    return (m == MODE_MIMO) ? RUN_MIMO : RUN_SISO;
  endfunction

  assign req_mode = mimo_req_i ? MODE_MIMO : MODE_SISO;
  assign mode_chg = (req_mode != mode_q) && !slot_phase_i;  // frame boundary only

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:               if (tx_en_i) state_d = run_of(mode_chg ? req_mode : mode_q);
      RUN_SISO, RUN_MIMO: if (!tx_en_i) state_d = IDLE;
                          else if (mode_chg) state_d = SWITCH;
      SWITCH:             state_d = tx_en_i ? run_of(mode_q) : IDLE;
      default:            state_d = IDLE;
    endcase
  end

  always_ff @(posedge radio_clk or posedge radio_rst) begin
    if (radio_rst) begin
      state_q <= IDLE;
      mode_q  <= MODE_SISO;
    end else begin
      state_q <= state_d;
      if (mode_chg) mode_q <= req_mode;
    end
  end

  assign mode_o      = mode_q;
  assign tx_active_o = (state_q == RUN_SISO) || (state_q == RUN_MIMO);

  // a change while running always lands in a quiet cycle
  a_quiet_on_change : assert property (@(posedge radio_clk) disable iff (radio_rst)
    ($changed(mode_o) && $past(tx_active_o)) |-> !tx_active_o);

endmodule

//--- verilog/radio_slot_timer.sv
//====================
// slot phase is 0 for channel 0, always 0 in SISO
// pair count wraps silently
//====================
`timescale 1ns/1ps
`include "radio_defs.svh"

module radio_slot_timer
  import radio_ctrl_pkg::*;
(
  input  logic                    radio_clk,
  input  logic                    radio_rst,
  input  bus_mode_t               mode_i,
  input  logic                    rx_stb_i,
  output logic                    slot_phase_o,
  output logic [`RADIO_CNT_W-1:0] rx_count_o
);

  logic                    slot_q;
  logic [`RADIO_CNT_W-1:0] cnt_q;

  always_ff @(posedge radio_clk or posedge radio_rst) begin
    if (radio_rst) begin
      slot_q <= 1'b0;
      cnt_q  <= '0;
    end else begin
      slot_q <= (mode_i == MODE_MIMO) ? ~slot_q : 1'b0;
      if (rx_stb_i) cnt_q <= cnt_q + 1'b1;  // one per delivered pair
    end
  end

  assign slot_phase_o = slot_q;
  assign rx_count_o   = cnt_q;

endmodule

//--- ddr_port/ddr_rx_capture.sv
//====================
// behavioral DDR capture, I on rise, Q on fall
// frame sampled on rise; pair out two rises after its I edge
//====================
`timescale 1ns/1ps
`include "radio_defs.svh"

module ddr_rx_capture
  import radio_sample_pkg::*;
  import radio_ctrl_pkg::*;
(
  input  logic                       radio_clk,
  input  logic                       radio_rst,
  input  bus_mode_t                  mode_i,
  input  logic [`RADIO_SAMPLE_W-1:0] rx_data_i,
  input  logic                       rx_frame_i,
  output chan_pair_t                 rx_pair_o,
  output logic                       rx_stb_o
);

  logic [`RADIO_SAMPLE_W-1:0] i_word_q;  // rise stage
  logic [`RADIO_SAMPLE_W-1:0] q_word_q;  // fall stage
  logic                       frame_q;
  logic                       cap_vld_q;
  iq_sample_t                 join_q;
  logic                       join_frame_q;
  logic                       join_vld_q;
  chan_pair_t                 pair_q;
  logic                       stb_q;

  always_ff @(negedge radio_clk) begin
    q_word_q <= rx_data_i;
  end

  always_ff @(posedge radio_clk) begin
    i_word_q   <= rx_data_i;
    join_q.i   <= i_word_q;
    join_q.q   <= q_word_q;   // Q of the previous I
  end

  // sort by channel
  always_ff @(posedge radio_clk) begin
    if (mode_i == MODE_SISO) begin
      pair_q.ch0 <= join_q;
      pair_q.ch1 <= join_q;
    end else if (join_frame_q) begin
      pair_q.ch0 <= join_q;
    end else begin
      pair_q.ch1 <= join_q;
    end
  end

  always_ff @(posedge radio_clk or posedge radio_rst) begin
    if (radio_rst) begin
      frame_q      <= 1'b0;
      cap_vld_q    <= 1'b0;
      join_frame_q <= 1'b0;
      join_vld_q   <= 1'b0;
      stb_q        <= 1'b0;
    end else begin
      frame_q      <= rx_frame_i;
      cap_vld_q    <= 1'b1;        // first I word is in
      join_frame_q <= frame_q;
      join_vld_q   <= cap_vld_q;
      if (mode_i == MODE_SISO) begin
        stb_q <= join_vld_q;
      end else begin
        stb_q <= join_vld_q & ~join_frame_q;  // strobe once channel 1 lands
      end
    end
  end

  assign rx_pair_o = pair_q;
  assign rx_stb_o  = stb_q;

endmodule

//--- ddr_port/ddr_tx_framer.sv
//====================
// behavioral DDR output with I while clock high and Q while low
// data and frame are zero when nothing was taken
//====================
`timescale 1ns/1ps
`include "radio_defs.svh"

module ddr_tx_framer
  import radio_sample_pkg::*;
  import radio_ctrl_pkg::*;
(
  input  logic                       radio_clk,
  input  logic                       radio_rst,
  input  bus_mode_t                  mode_i,
  input  logic                       tx_active_i,
  input  logic                       slot_phase_i,
  input  chan_pair_t                 tx_pair_i,
  output logic                       tx_stb_o,
  output logic [`RADIO_SAMPLE_W-1:0] tx_data_o,
  output logic                       tx_frame_o
);

  iq_sample_t cur_q;       // sample on the bus this cycle
  iq_sample_t hold_q;      // channel 1 of the last take
  iq_sample_t out_smp;
  logic       out_vld_q;
  logic       hold_vld_q;
  logic       frame_q;
  logic       siso_q;

  assign tx_stb_o = tx_active_i & ((mode_i == MODE_SISO) | ~slot_phase_i);

  always_ff @(posedge radio_clk) begin
    if (tx_stb_o) begin
      cur_q  <= tx_pair_i.ch0;
      hold_q <= tx_pair_i.ch1;
    end else begin
      cur_q  <= hold_q;   // MIMO second cycle
    end
  end

  always_ff @(posedge radio_clk or posedge radio_rst) begin
    if (radio_rst) begin
      out_vld_q  <= 1'b0;
      hold_vld_q <= 1'b0;
      frame_q    <= 1'b0;
      siso_q     <= 1'b1;
    end else begin
      out_vld_q  <= tx_stb_o | hold_vld_q;
      hold_vld_q <= tx_stb_o & (mode_i == MODE_MIMO);
      frame_q    <= tx_stb_o;   // channel 0 cycle
      siso_q     <= (mode_i == MODE_SISO);
    end
  end

  // SISO falls back to channel 1 when channel 0 is all zeros
  assign out_smp = (siso_q && cur_q == '0) ? hold_q : cur_q;

  assign tx_data_o  = !out_vld_q ? '0 : (radio_clk ? out_smp.i : out_smp.q);
  assign tx_frame_o = out_vld_q & frame_q & (radio_clk | ~siso_q);  // I half only in SISO

  // held channel 1 never overwritten by a new take
  a_hold_no_take : assert property (@(posedge radio_clk) disable iff (radio_rst)
    hold_vld_q |-> !tx_stb_o);

endmodule

//--- verilog/radio_if_top.sv
//====================
// single clock radio port, inputs already synchronous
// rx_stb has no back-pressure
//====================
`timescale 1ns/1ps
`include "radio_defs.svh"

module radio_if_top
  import radio_sample_pkg::*;
  import radio_ctrl_pkg::*;
(
  input  logic                       radio_clk,
  input  logic                       radio_rst,
  input  wb_req_t                    wb_req_i,
  output wb_rsp_t                    wb_rsp_o,
  input  logic [`RADIO_SAMPLE_W-1:0] rx_data_i,
  input  logic                       rx_frame_i,
  output chan_pair_t                 rx_pair_o,
  output logic                       rx_stb_o,
  input  chan_pair_t                 tx_pair_i,
  output logic                       tx_stb_o,
  output logic [`RADIO_SAMPLE_W-1:0] tx_data_o,
  output logic                       tx_frame_o
);

  bus_mode_t               mode;
  logic                    mimo_req;
  logic                    tx_en;
  logic                    tx_active;
  logic                    slot_phase;
  logic [`RADIO_CNT_W-1:0] rx_count;

  radio_ctrl_regs radio_ctrl_regs_inst (
    .radio_clk   (radio_clk),
    .radio_rst   (radio_rst),
    .wb_req_i    (wb_req_i),
    .wb_rsp_o    (wb_rsp_o),
    .mode_i      (mode),
    .tx_active_i (tx_active),
    .rx_count_i  (rx_count),
    .mimo_req_o  (mimo_req),
    .tx_en_o     (tx_en)
  );

  radio_mode_fsm radio_mode_fsm_inst (
    .radio_clk    (radio_clk),
    .radio_rst    (radio_rst),
    .mimo_req_i   (mimo_req),
    .tx_en_i      (tx_en),
    .slot_phase_i (slot_phase),
    .mode_o       (mode),
    .tx_active_o  (tx_active)
  );

  radio_slot_timer radio_slot_timer_inst (
    .radio_clk    (radio_clk),
    .radio_rst    (radio_rst),
    .mode_i       (mode),
    .rx_stb_i     (rx_stb_o),
    .slot_phase_o (slot_phase),
    .rx_count_o   (rx_count)
  );

  ddr_rx_capture ddr_rx_capture_inst (
    .radio_clk  (radio_clk),
    .radio_rst  (radio_rst),
    .mode_i     (mode),
    .rx_data_i  (rx_data_i),
    .rx_frame_i (rx_frame_i),
    .rx_pair_o  (rx_pair_o),
    .rx_stb_o   (rx_stb_o)
  );

  ddr_tx_framer ddr_tx_framer_inst (
    .radio_clk    (radio_clk),
    .radio_rst    (radio_rst),
    .mode_i       (mode),
    .tx_active_i  (tx_active),
    .slot_phase_i (slot_phase),
    .tx_pair_i    (tx_pair_i),
    .tx_stb_o     (tx_stb_o),
    .tx_data_o    (tx_data_o),
    .tx_frame_o   (tx_frame_o)
  );

endmodule

//--- verification/radio_if_tb.sv
//====================
// radio port testbench, stops at the first mismatch
// rx and tx checks count on the fixed DDR path latency
//====================
`timescale 1ns/1ps
`include "radio_defs.svh"

module radio_if_tb
  import radio_sample_pkg::*;
  import radio_ctrl_pkg::*;
();

  localparam int ROWS   = 16;
  localparam int SISO_N = 8;   // rows before the switch to MIMO
  localparam int WB_TMO = 8;

  // one bus cycle of stimulus and what it should produce
  typedef struct packed {
    bus_mode_t  mode;
    iq_sample_t rx;
    logic       frame;
    chan_pair_t tx;
    logic       exp_rx_stb;
    chan_pair_t exp_rx;
    logic       exp_tx_stb;
    iq_sample_t exp_tx;
    logic       exp_fr_i;
    logic       exp_fr_q;
  } row_t;

  logic                       radio_clk;
  logic                       radio_rst;
  wb_req_t                    wb_req;
  wb_rsp_t                    wb_rsp;
  logic [`RADIO_SAMPLE_W-1:0] rx_data;
  logic                       rx_frame;
  chan_pair_t                 rx_pair;
  logic                       rx_stb;
  chan_pair_t                 tx_pair;
  logic                       tx_stb;
  logic [`RADIO_SAMPLE_W-1:0] tx_data;
  logic                       tx_frame;

  row_t        tbl [ROWS];
  logic [31:0] lfsr;
  int          rx_seen = 0;   // strobes seen since reset

  radio_if_top radio_if_top_inst (
    .radio_clk  (radio_clk),
    .radio_rst  (radio_rst),
    .wb_req_i   (wb_req),
    .wb_rsp_o   (wb_rsp),
    .rx_data_i  (rx_data),
    .rx_frame_i (rx_frame),
    .rx_pair_o  (rx_pair),
    .rx_stb_o   (rx_stb),
    .tx_pair_i  (tx_pair),
    .tx_stb_o   (tx_stb),
    .tx_data_o  (tx_data),
    .tx_frame_o (tx_frame)
  );

  initial begin
    radio_clk = 1'b0;
    forever #10 radio_clk = ~radio_clk;
  end

  always @(negedge radio_clk) begin
    if (!radio_rst && rx_stb) rx_seen <= rx_seen + 1;
  end

  // x^32 + x^22 + x^2 + x + 1, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic iq_sample_t rand_sample();
    logic [31:0] v;
    v = rand_bits(2 * `RADIO_SAMPLE_W);
    return v[2*`RADIO_SAMPLE_W-1:0];
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("ERROR %s got %h expected %h", name, got, exp);
      $display("Finished with errors");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic timeout_fail(input string what);
    $display("timed out waiting for %s", what);
    $display("Finished with errors");
    $fatal(1, "wait timeout");
  endtask

  // request held through the ack cycle, starts and ends 2 ns after a rise
  task automatic wb_access(input logic we, input logic [1:0] adr,
                           input logic [31:0] wdat, output logic [31:0] rdat);
    int n;
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
    n = 0;
    do begin
      @(posedge radio_clk);
      #2;
      n++;
    end while (!wb_rsp.ack && n < WB_TMO);
    if (!wb_rsp.ack) timeout_fail("wishbone ack");
    rdat = wb_rsp.dat;
    @(posedge radio_clk);
    #2;
    wb_req = '0;
  endtask

  task automatic wb_write(input logic [1:0] adr, input logic [31:0] dat);
    logic [31:0] rsp_dat;
    wb_access(1'b1, adr, dat, rsp_dat);
  endtask

  task automatic wb_read(input logic [1:0] adr, output logic [31:0] dat);
    wb_access(1'b0, adr, 32'd0, dat);
  endtask

  task automatic wait_status(input logic [1:0] want);
    logic [31:0] st;
    int n;
    n = 0;
    do begin
      wb_read(`RADIO_REG_STATUS, st);
      n++;
    end while (st[1:0] != want && n < 6);
    if (st[1:0] != want) timeout_fail("status mode and transmit state");
  endtask

  task automatic fill_table();
    logic even;
    for (int r = 0; r < ROWS; r++) begin
      tbl[r].mode = (r < SISO_N) ? MODE_SISO : MODE_MIMO;
      tbl[r].rx   = rand_sample();
      tbl[r].tx   = {rand_sample(), rand_sample()};
      if (r < SISO_N) begin
        if (r % 3 == 2) tbl[r].tx.ch0 = '0;   // channel 1 fallback
        tbl[r].frame      = 1'b1;
        tbl[r].exp_rx_stb = 1'b1;
        tbl[r].exp_rx     = {tbl[r].rx, tbl[r].rx};
        tbl[r].exp_tx_stb = 1'b1;
        if (tbl[r].tx.ch0 != '0) tbl[r].exp_tx = tbl[r].tx.ch0;
        else tbl[r].exp_tx = tbl[r].tx.ch1;
        tbl[r].exp_fr_i   = 1'b1;
        tbl[r].exp_fr_q   = 1'b0;
      end else begin
        even              = ((r - SISO_N) % 2 == 0);   // channel 0 cycle
        tbl[r].frame      = even;
        tbl[r].exp_rx_stb = !even;
        tbl[r].exp_tx_stb = even;
        tbl[r].exp_fr_i   = even;
        tbl[r].exp_fr_q   = even;
        if (even) begin
          tbl[r].exp_rx = '0;
          tbl[r].exp_tx = tbl[r].tx.ch0;
        end else begin
          tbl[r].exp_rx = {tbl[r-1].rx, tbl[r].rx};
          tbl[r].exp_tx = tbl[r-1].tx.ch1;      // held from the take
        end
      end
    end
  endtask

  // rx pair of row r shows in cycle r+3, tx sample of row r in cycle r+1
  task automatic run_block(input int first, input int n);
    int w;
    wait_status({1'b1, tbl[first].mode});
    w = 0;
    while (!tx_stb && w < 4) begin   // start on a channel 0 slot
      @(posedge radio_clk);
      #2;
      w++;
    end
    if (!tx_stb) timeout_fail("first transmit strobe");
    for (int c = 0; c < n + 3; c++) begin
      rx_data  = '0;
      rx_frame = 1'b1;
      tx_pair  = '0;
      if (c > 0 && c <= n) rx_data = tbl[first+c-1].rx.q;
      if (c < n) begin
        rx_frame = tbl[first+c].frame;
        tx_pair  = tbl[first+c].tx;
        check_value("tx_stb", tx_stb, tbl[first+c].exp_tx_stb);
      end
      #3;
      if (c >= 3) begin
        check_value("rx_stb", rx_stb, tbl[first+c-3].exp_rx_stb);
        if (tbl[first+c-3].exp_rx_stb) begin
          check_value("rx_pair", rx_pair, tbl[first+c-3].exp_rx);
        end
      end
      if (c >= 1 && c <= n) begin   // clock high, I half
        check_value("tx_data", tx_data, tbl[first+c-1].exp_tx.i);
        check_value("tx_frame", tx_frame, tbl[first+c-1].exp_fr_i);
      end
      @(negedge radio_clk);
      #2;
      rx_data = '0;
      if (c < n) rx_data = tbl[first+c].rx.i;
      #3;
      if (c >= 1 && c <= n) begin   // clock low, Q half
        check_value("tx_data", tx_data, tbl[first+c-1].exp_tx.q);
        check_value("tx_frame", tx_frame, tbl[first+c-1].exp_fr_q);
      end
      @(posedge radio_clk);
      #2;
    end
  endtask

  initial begin
    logic [31:0] rd;
    radio_rst = 1'b1;
    wb_req    = '0;
    rx_data   = '0;
    rx_frame  = 1'b1;
    tx_pair   = '0;
    lfsr      = 32'hfcd7_4c9b;
    fill_table();
    repeat (3) @(posedge radio_clk);
    #2;
    radio_rst = 1'b0;

    check_value("rx_stb", rx_stb, 1'b0);
    check_value("tx_stb", tx_stb, 1'b0);
    check_value("tx_frame", tx_frame, 1'b0);
    wb_read(`RADIO_REG_STATUS, rd);
    check_value("status", rd, 32'd0);
    wb_read(`RADIO_REG_CTRL, rd);
    check_value("ctrl", rd, 32'd0);

    wb_write(`RADIO_REG_CTRL, 32'h2);   // SISO, transmit on
    wb_read(`RADIO_REG_CTRL, rd);
    check_value("ctrl", rd, 32'h2);
    run_block(0, SISO_N);

    wb_write(`RADIO_REG_CTRL, 32'h3);   // MIMO, transmit on
    wb_read(`RADIO_REG_CTRL, rd);
    check_value("ctrl", rd, 32'h3);
    run_block(SISO_N, ROWS - SISO_N);

    // frame held high in MIMO, so no strobes after the last pair
    wb_read(`RADIO_REG_STATUS, rd);
    check_value("rx_count", rd[31:16], rx_seen[15:0]);

    $display("Finished with no errors");
    $finish;
  end

endmodule

//--- radio_if.f
+incdir+common
common/radio_sample_pkg.sv
common/radio_ctrl_pkg.sv
verilog/radio_ctrl_regs.sv
verilog/radio_mode_fsm.sv
verilog/radio_slot_timer.sv
ddr_port/ddr_rx_capture.sv
ddr_port/ddr_tx_framer.sv
verilog/radio_if_top.sv
verification/radio_if_tb.sv

//--- Makefile
# Verilator build and run of the radio port testbench

VERILATOR ?= verilator
TOP       ?= radio_if_tb
FLIST     ?= radio_if.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal
PASS_MSG  ?= Finished with no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
